// File: dcache_cases.txt
# cmd addr data resp rtag rdata | expected: cmd addr data hit resp rtag data_out
# all hex, cmd 0 none 1 load 2 store, one line per clock cycle
0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0
1 100c 0 0 0 0 1 1008 0 0 0 0 0
1 100c 0 3 0 0 1 1008 0 0 3 0 0
1 2010 0 5 0 0 1 2010 0 0 5 0 0
0 0 0 0 5 bbbb 0 0 0 0 0 5 bbbb
0 0 0 0 3 aaaa 0 0 0 0 0 3 aaaa
1 1008 0 0 0 0 0 0 0 1 0 0 aaaa
1 2010 0 7 0 0 0 0 0 1 0 0 bbbb
2 1008 123456789abcdef0 0 0 0 0 0 0 1 0 0 0
1 1008 0 0 0 0 0 0 0 1 0 0 123456789abcdef0
1 3008 0 0 0 0 2 1008 123456789abcdef0 0 0 0 0
1 3008 0 2 0 0 2 1008 123456789abcdef0 0 2 0 0
1 3008 0 0 0 0 1 3008 0 0 0 0 0
1 3008 0 4 0 0 1 3008 0 0 4 0 0
0 0 0 0 9 dead 0 0 0 0 0 0 0
0 0 0 0 4 cccc 0 0 0 0 0 4 cccc
1 3008 0 0 0 0 0 0 0 1 0 0 cccc
0 0 0 0 3 5555 0 0 0 0 0 0 0
1 3008 0 0 0 0 0 0 0 1 0 0 cccc
1 1008 0 0 0 0 1 1008 0 0 0 0 0
1 4018 0 0 0 0 1 4018 0 0 0 0 0
1 2010 0 0 0 0 0 0 0 1 0 0 bbbb
0 0 0 0 0 0 0 0 0 0 0 0 0

// File: src.f
dcache_pkg.sv
dcache_controller.sv
dcache_mem.sv
fill_tracker.sv
dcache_top.sv
dcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module dcache_tb -o dcache_sim

output=$(./obj_dir/dcache_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
	exit 0
else
	exit 1
fi

// File: dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	logic                                   clock;
	logic                                   reset;
	dcache_pkg::bus_command                 proc2dcache_command;
	logic [dcache_pkg::ADDR_W-1:0]          proc2dcache_addr;
	logic [dcache_pkg::DATA_W-1:0]          proc2dcache_data;
	logic [dcache_pkg::MEM_TAG_W-1:0]       dmem2proc_response;
	logic [dcache_pkg::MEM_TAG_W-1:0]       dmem2proc_tag;
	logic [dcache_pkg::DATA_W-1:0]          dmem2proc_data;
	dcache_pkg::bus_command                 proc2dmem_command;
	logic [dcache_pkg::ADDR_W-1:0]          proc2dmem_addr;
	logic [dcache_pkg::DATA_W-1:0]          proc2dmem_data;
	logic [dcache_pkg::DATA_W-1:0]          dcache_data_out;
	logic                                   dcache_data_hit;
	logic [dcache_pkg::MEM_TAG_W-1:0]       dcache2proc_response;
	logic [dcache_pkg::MEM_TAG_W-1:0]       dcache2proc_tag;

	// six stimulus columns then seven expected columns per cycle
	logic [63:0]                            stim [0:63][0:12];
	int                                     num_cases;
	logic                                   cases_ready;

	dcache_top dcache_top_i (
		.clock                (clock),
		.reset                (reset),
		.proc2dcache_command  (proc2dcache_command),
		.proc2dcache_addr     (proc2dcache_addr),
		.proc2dcache_data     (proc2dcache_data),
		.dmem2proc_response   (dmem2proc_response),
		.dmem2proc_tag        (dmem2proc_tag),
		.dmem2proc_data       (dmem2proc_data),
		.proc2dmem_command    (proc2dmem_command),
		.proc2dmem_addr       (proc2dmem_addr),
		.proc2dmem_data       (proc2dmem_data),
		.dcache_data_out      (dcache_data_out),
		.dcache_data_hit      (dcache_data_hit),
		.dcache2proc_response (dcache2proc_response),
		.dcache2proc_tag      (dcache2proc_tag)
	);

	task automatic check(input int idx, input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH case %0d %s: got %h, expected %h", idx, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "output check failed");
		end
	endtask

	task automatic load_cases();
		int                             fd;
		int                             code;
		int                             n;
		string                          line;
		logic [63:0]                    f [0:12];
		fd = $fopen("dcache_cases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open dcache_cases.txt");
			$display("Some tests failed");
			$fatal(1, "missing cases file");
		end
		num_cases = 0;
		while (!$feof(fd) && num_cases < 64)
		begin
			code = $fgets(line, fd);
			// skip blank and comment lines
			if (code > 0 && line.getc(0) != 8'h23)
			begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
					f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
				if (n == 13)
				begin
					for (int k = 0; k < 13; k++)
						stim[num_cases][k] = f[k];
					num_cases++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_case(input int idx);
		proc2dcache_command = dcache_pkg::bus_command'(stim[idx][0][1:0]);
		proc2dcache_addr    = stim[idx][1];
		proc2dcache_data    = stim[idx][2];
		dmem2proc_response  = stim[idx][3][dcache_pkg::MEM_TAG_W-1:0];
		dmem2proc_tag       = stim[idx][4][dcache_pkg::MEM_TAG_W-1:0];
		dmem2proc_data      = stim[idx][5];
	endtask

	task automatic check_case(input int idx);
		check(idx, "proc2dmem_command", 64'(proc2dmem_command), stim[idx][6]);
		check(idx, "proc2dmem_addr", proc2dmem_addr, stim[idx][7]);
		check(idx, "proc2dmem_data", proc2dmem_data, stim[idx][8]);
		check(idx, "dcache_data_hit", 64'(dcache_data_hit), stim[idx][9]);
		check(idx, "dcache2proc_response", 64'(dcache2proc_response), stim[idx][10]);
		check(idx, "dcache2proc_tag", 64'(dcache2proc_tag), stim[idx][11]);
		check(idx, "dcache_data_out", dcache_data_out, stim[idx][12]);
	endtask

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// limit scales with the number of cycles in the cases file
	initial
	begin
		wait (cases_ready);
		#(num_cases * 20 + 400);
		$display("timeout: simulation ran past the watchdog limit");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		reset               = 1'b1;
		cases_ready         = 1'b0;
		proc2dcache_command = dcache_pkg::BUS_NONE;
		proc2dcache_addr    = '0;
		proc2dcache_data    = '0;
		dmem2proc_response  = '0;
		dmem2proc_tag       = '0;
		dmem2proc_data      = '0;
		load_cases();
		if (num_cases == 0)
		begin
			$display("no cases found in dcache_cases.txt");
			$display("Some tests failed");
			$fatal(1, "empty cases file");
		end
		cases_ready = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < num_cases; i++)
		begin
			drive_case(i);
			// sample just ahead of the rising edge
			#9;
			check_case(i);
			@(negedge clock);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  logic                                    clock,
	input  logic                                    reset,

	// processor side
	input  dcache_pkg::bus_command                  proc2dcache_command,
	input  logic [dcache_pkg::ADDR_W-1:0]           proc2dcache_addr,
	input  logic [dcache_pkg::DATA_W-1:0]           proc2dcache_data,

	// memory side
	input  logic [dcache_pkg::MEM_TAG_W-1:0]        dmem2proc_response,
	input  logic [dcache_pkg::MEM_TAG_W-1:0]        dmem2proc_tag,
	input  logic [dcache_pkg::DATA_W-1:0]           dmem2proc_data,

	output dcache_pkg::bus_command                  proc2dmem_command,
	output logic [dcache_pkg::ADDR_W-1:0]           proc2dmem_addr,
	output logic [dcache_pkg::DATA_W-1:0]           proc2dmem_data,

	output logic [dcache_pkg::DATA_W-1:0]           dcache_data_out,
	output logic                                    dcache_data_hit,
	output logic [dcache_pkg::MEM_TAG_W-1:0]        dcache2proc_response,
	output logic [dcache_pkg::MEM_TAG_W-1:0]        dcache2proc_tag
);

	logic [dcache_pkg::INDEX_W-1:0]         index;
	logic [dcache_pkg::CACHE_TAG_W-1:0]     tag;
	logic                                   read_enable;
	logic                                   write_enable;
	logic [dcache_pkg::DATA_W-1:0]          write_data;
	logic                                   writeback_accept;
	logic                                   miss_record;
	logic [dcache_pkg::MEM_TAG_W-1:0]       mem_response;
	logic [dcache_pkg::DATA_W-1:0]          hit_data;

	logic                                   cachemem_is_miss;
	logic                                   cachemem_is_dirty;
	logic [dcache_pkg::DATA_W-1:0]          cachemem_data;
	logic [dcache_pkg::CACHE_TAG_W-1:0]     victim_tag;
	logic [dcache_pkg::DATA_W-1:0]          victim_data;

	logic                                   fill_valid;
	logic [dcache_pkg::INDEX_W-1:0]         fill_index;
	logic [dcache_pkg::CACHE_TAG_W-1:0]     fill_tag;
	logic [dcache_pkg::DATA_W-1:0]          fill_data;
	logic [dcache_pkg::DATA_W-1:0]          dcache_data_out_fill;

	dcache_controller controller_i (
		.proc2dcache_command  (proc2dcache_command),
		.proc2dcache_addr     (proc2dcache_addr),
		.proc2dcache_data     (proc2dcache_data),
		.dmem2proc_response   (dmem2proc_response),
		.cachemem_is_miss     (cachemem_is_miss),
		.cachemem_is_dirty    (cachemem_is_dirty),
		.cachemem_data        (cachemem_data),
		.victim_tag           (victim_tag),
		.victim_data          (victim_data),
		.index                (index),
		.tag                  (tag),
		.read_enable          (read_enable),
		.write_enable         (write_enable),
		.write_data           (write_data),
		.writeback_accept     (writeback_accept),
		.miss_record          (miss_record),
		.mem_response         (mem_response),
		.proc2dmem_command    (proc2dmem_command),
		.proc2dmem_addr       (proc2dmem_addr),
		.proc2dmem_data       (proc2dmem_data),
		.dcache_data_hit      (dcache_data_hit),
		.dcache2proc_response (dcache2proc_response),
		.hit_data             (hit_data)
	);

	dcache_mem mem_i (
		.clock             (clock),
		.reset             (reset),
		.index             (index),
		.tag               (tag),
		.read_enable       (read_enable),
		.write_enable      (write_enable),
		.write_data        (write_data),
		.writeback_accept  (writeback_accept),
		.fill_valid        (fill_valid),
		.fill_index        (fill_index),
		.fill_tag          (fill_tag),
		.fill_data         (fill_data),
		.cachemem_is_miss  (cachemem_is_miss),
		.cachemem_is_dirty (cachemem_is_dirty),
		.cachemem_data     (cachemem_data),
		.victim_tag        (victim_tag),
		.victim_data       (victim_data)
	);

	fill_tracker tracker_i (
		.clock                (clock),
		.reset                (reset),
		.miss_record          (miss_record),
		.mem_response         (mem_response),
		.index                (index),
		.tag                  (tag),
		.dmem2proc_tag        (dmem2proc_tag),
		.dmem2proc_data       (dmem2proc_data),
		.fill_valid           (fill_valid),
		.fill_index           (fill_index),
		.fill_tag             (fill_tag),
		.fill_data            (fill_data),
		.dcache2proc_tag      (dcache2proc_tag),
		.dcache_data_out_fill (dcache_data_out_fill)
	);

	// a finished load takes the data port over a hit
	assign dcache_data_out = (dcache2proc_tag != '0) ? dcache_data_out_fill : hit_data;

endmodule

`default_nettype wire

// File: fill_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module fill_tracker (
	input  logic                                    clock,
	input  logic                                    reset,

	// clean miss accepted by memory this cycle
	input  logic                                    miss_record,
	input  logic [dcache_pkg::MEM_TAG_W-1:0]        mem_response,
	input  logic [dcache_pkg::INDEX_W-1:0]          index,
	input  logic [dcache_pkg::CACHE_TAG_W-1:0]      tag,

	// load returning from memory
	input  logic [dcache_pkg::MEM_TAG_W-1:0]        dmem2proc_tag,
	input  logic [dcache_pkg::DATA_W-1:0]           dmem2proc_data,

	// fill into the cache arrays
	output logic                                    fill_valid,
	output logic [dcache_pkg::INDEX_W-1:0]          fill_index,
	output logic [dcache_pkg::CACHE_TAG_W-1:0]      fill_tag,
	output logic [dcache_pkg::DATA_W-1:0]           fill_data,

	// finished load report to the processor
	output logic [dcache_pkg::MEM_TAG_W-1:0]        dcache2proc_tag,
	output logic [dcache_pkg::DATA_W-1:0]           dcache_data_out_fill
);

	// one entry per memory tag, entry 0 never used
	logic [dcache_pkg::MEM_TAGS-1:0]        entry_valid;
	logic [dcache_pkg::INDEX_W-1:0]         entry_index [dcache_pkg::MEM_TAGS];
	logic [dcache_pkg::CACHE_TAG_W-1:0]     entry_tag   [dcache_pkg::MEM_TAGS];

	logic                                   return_hit;

	// unknown tags fall through as no return
	assign return_hit = (dmem2proc_tag != '0) && entry_valid[dmem2proc_tag];

	assign fill_valid = return_hit;
	assign fill_index = entry_index[dmem2proc_tag];
	assign fill_tag   = entry_tag[dmem2proc_tag];
	assign fill_data  = dmem2proc_data;

	always_comb
	begin
		if (return_hit)
		begin
			dcache2proc_tag      = dmem2proc_tag;
			dcache_data_out_fill = dmem2proc_data;
		end
		else
		begin
			dcache2proc_tag      = '0;
			dcache_data_out_fill = '0;
		end
	end

	// line address of each outstanding load
	always_ff @(posedge clock)
	begin
		if (miss_record)
		begin
			entry_index[mem_response] <= index;
			entry_tag[mem_response]   <= tag;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			entry_valid <= '0;
		else
		begin
			if (return_hit)
				entry_valid[dmem2proc_tag] <= 1'b0;
			// a tag reissued in the same cycle stays held
			if (miss_record)
				entry_valid[mem_response] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: dcache_mem.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem (
	input  logic                                    clock,
	input  logic                                    reset,

	// lookup and store from the controller
	input  logic [dcache_pkg::INDEX_W-1:0]          index,
	input  logic [dcache_pkg::CACHE_TAG_W-1:0]      tag,
	input  logic                                    read_enable,
	input  logic                                    write_enable,
	input  logic [dcache_pkg::DATA_W-1:0]           write_data,
	input  logic                                    writeback_accept,

	// block arriving from memory
	input  logic                                    fill_valid,
	input  logic [dcache_pkg::INDEX_W-1:0]          fill_index,
	input  logic [dcache_pkg::CACHE_TAG_W-1:0]      fill_tag,
	input  logic [dcache_pkg::DATA_W-1:0]           fill_data,

	// lookup result
	output logic                                    cachemem_is_miss,
	output logic                                    cachemem_is_dirty,
	output logic [dcache_pkg::DATA_W-1:0]           cachemem_data,
	output logic [dcache_pkg::CACHE_TAG_W-1:0]      victim_tag,
	output logic [dcache_pkg::DATA_W-1:0]           victim_data
);

	logic [dcache_pkg::DATA_W-1:0]          data_array [dcache_pkg::LINES];
	logic [dcache_pkg::CACHE_TAG_W-1:0]     tag_array  [dcache_pkg::LINES];
	logic [dcache_pkg::LINES-1:0]           valid;
	logic [dcache_pkg::LINES-1:0]           dirty;

	logic                                   tag_match;
	logic                                   fill_same_line;
	logic                                   store_write;

	// combinational lookup
	assign tag_match        = valid[index] && (tag_array[index] == tag);
	assign cachemem_is_miss = !tag_match;
	// dirty bit belongs to whatever line sits at this index
	assign cachemem_is_dirty = valid[index] && dirty[index];

	always_comb
	begin
		if (read_enable)
			cachemem_data = data_array[index];
		else
			cachemem_data = '0;
	end

	assign victim_tag  = tag_array[index];
	assign victim_data = data_array[index];

	// a fill to the same line overrides the store
	assign fill_same_line = fill_valid && (fill_index == index);
	assign store_write    = write_enable && tag_match && !fill_same_line;

	// tag and data storage
	always_ff @(posedge clock)
	begin
		if (fill_valid)
		begin
			data_array[fill_index] <= fill_data;
			tag_array[fill_index]  <= fill_tag;
		end
		if (store_write)
			data_array[index] <= write_data;
	end

	// line state
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else
		begin
			if (store_write)
				dirty[index] <= 1'b1;
			else if (writeback_accept && !fill_same_line)
				dirty[index] <= 1'b0;

			// fresh block from memory is clean
			if (fill_valid)
			begin
				valid[fill_index] <= 1'b1;
				dirty[fill_index] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: dcache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_controller (
	// request from the load/store unit
	input  dcache_pkg::bus_command                  proc2dcache_command,
	input  logic [dcache_pkg::ADDR_W-1:0]           proc2dcache_addr,
	input  logic [dcache_pkg::DATA_W-1:0]           proc2dcache_data,

	// acceptance of the command issued this cycle
	input  logic [dcache_pkg::MEM_TAG_W-1:0]        dmem2proc_response,

	// lookup result from the cache arrays
	input  logic                                    cachemem_is_miss,
	input  logic                                    cachemem_is_dirty,
	input  logic [dcache_pkg::DATA_W-1:0]           cachemem_data,
	input  logic [dcache_pkg::CACHE_TAG_W-1:0]      victim_tag,
	input  logic [dcache_pkg::DATA_W-1:0]           victim_data,

	// to the cache arrays
	output logic [dcache_pkg::INDEX_W-1:0]          index,
	output logic [dcache_pkg::CACHE_TAG_W-1:0]      tag,
	output logic                                    read_enable,
	output logic                                    write_enable,
	output logic [dcache_pkg::DATA_W-1:0]           write_data,
	output logic                                    writeback_accept,

	// to the fill tracker
	output logic                                    miss_record,
	output logic [dcache_pkg::MEM_TAG_W-1:0]        mem_response,

	// to the memory bus
	output dcache_pkg::bus_command                  proc2dmem_command,
	output logic [dcache_pkg::ADDR_W-1:0]           proc2dmem_addr,
	output logic [dcache_pkg::DATA_W-1:0]           proc2dmem_data,

	// back to the processor
	output logic                                    dcache_data_hit,
	output logic [dcache_pkg::MEM_TAG_W-1:0]        dcache2proc_response,
	output logic [dcache_pkg::DATA_W-1:0]           hit_data
);

	typedef enum logic [1:0]
	{
		OUT_IDLE,
		OUT_HIT,
		OUT_LOAD,
		OUT_WRITEBACK
	} outcome_t;

	outcome_t                               outcome;
	logic                                   is_load;
	logic                                   is_store;
	logic                                   accepted;
	logic [dcache_pkg::ADDR_W-1:0]          block_addr;
	logic [dcache_pkg::ADDR_W-1:0]          victim_addr;

	// address split, offset bits dropped
	assign {tag, index} = proc2dcache_addr[dcache_pkg::ADDR_W-1:dcache_pkg::BLOCK_OFFSET];

	assign is_load  = (proc2dcache_command == dcache_pkg::BUS_LOAD);
	assign is_store = (proc2dcache_command == dcache_pkg::BUS_STORE);
	assign accepted = (dmem2proc_response != '0);

	assign block_addr  = {proc2dcache_addr[dcache_pkg::ADDR_W-1:dcache_pkg::BLOCK_OFFSET],
		{dcache_pkg::BLOCK_OFFSET{1'b0}}};
	// resident line's address, rebuilt from its stored tag
	assign victim_addr = {victim_tag, index, {dcache_pkg::BLOCK_OFFSET{1'b0}}};

	// classify the request
	always_comb
	begin
		if (!is_load && !is_store)
			outcome = OUT_IDLE;
		else if (!cachemem_is_miss)
			outcome = OUT_HIT;
		else if (cachemem_is_dirty)
			outcome = OUT_WRITEBACK;
		else
			outcome = OUT_LOAD;
	end

	// drive bus, array enables and processor response from the outcome
	always_comb
	begin
		proc2dmem_command    = dcache_pkg::BUS_NONE;
		proc2dmem_addr       = '0;
		proc2dmem_data       = '0;
		dcache2proc_response = '0;
		dcache_data_hit      = 1'b0;
		write_enable         = 1'b0;
		writeback_accept     = 1'b0;
		miss_record          = 1'b0;
		hit_data             = '0;
		case (outcome)
			OUT_HIT:
			begin
				dcache_data_hit = 1'b1;
				// stores land in the array at the next edge
				write_enable    = is_store;
				if (is_load)
					hit_data = cachemem_data;
			end
			OUT_LOAD:
			begin
				proc2dmem_command    = dcache_pkg::BUS_LOAD;
				proc2dmem_addr       = block_addr;
				dcache2proc_response = dmem2proc_response;
				// store misses also fetch the block, then retry as a hit
				miss_record          = accepted;
			end
			OUT_WRITEBACK:
			begin
				proc2dmem_command    = dcache_pkg::BUS_STORE;
				proc2dmem_addr       = victim_addr;
				proc2dmem_data       = victim_data;
				dcache2proc_response = dmem2proc_response;
				writeback_accept     = accepted;
			end
			default:
			begin
				proc2dmem_command = dcache_pkg::BUS_NONE;
			end
		endcase
	end

	// data read only matters for loads
	assign read_enable  = is_load;
	assign write_data   = proc2dcache_data;
	// tracker only sees tags of commands actually issued
	assign mem_response = dcache2proc_response;

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// command encoding shared by the processor and the memory bus
	typedef enum logic [1:0]
	{
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command;

	// address and data widths
	localparam int ADDR_W = 64;
	localparam int DATA_W = 64;

	// memory transaction tag, value 0 means no transaction
	localparam int MEM_TAG_W = 4;
	localparam int MEM_TAGS = 2 ** MEM_TAG_W;

	// one 64-bit word per block
	localparam int BLOCK_OFFSET = 3;

	// direct mapped, 32 lines
	localparam int INDEX_W = 5;
	localparam int LINES = 2 ** INDEX_W;

	// what is left of the address after index and offset
	localparam int CACHE_TAG_W = ADDR_W - INDEX_W - BLOCK_OFFSET;

endpackage

`default_nettype wire
